// ==== common/aluPkg.sv ====
`default_nettype none

package aluPkg;

	// ----------------------------------------
	// opcodes
	// ----------------------------------------

	// add family
	localparam logic [4:0] opAdd = 5'b00000;
	localparam logic [4:0] opAddi = 5'b00001;
	localparam logic [4:0] opAddu = 5'b00010;
	localparam logic [4:0] opAddui = 5'b00011;
	localparam logic [4:0] opAddc = 5'b00100;
	localparam logic [4:0] opAddcu = 5'b00101;
	localparam logic [4:0] opAddcui = 5'b00110;
	localparam logic [4:0] opAddci = 5'b00111;
	// subtract and compare
	localparam logic [4:0] opSub = 5'b01000;
	localparam logic [4:0] opSubi = 5'b01001;
	localparam logic [4:0] opCmp = 5'b01010;
	localparam logic [4:0] opCmpi = 5'b01011;
	localparam logic [4:0] opCmpui = 5'b01100;
	// bitwise logic
	localparam logic [4:0] opAnd = 5'b01101;
	localparam logic [4:0] opOr = 5'b01110;
	localparam logic [4:0] opXor = 5'b01111;
	localparam logic [4:0] opNot = 5'b10000;
	// shifts
	// 10101 stays unused and acts as a no-op
	localparam logic [4:0] opLsh = 5'b10001;
	localparam logic [4:0] opLshi = 5'b10010;
	localparam logic [4:0] opRsh = 5'b10011;
	localparam logic [4:0] opRshi = 5'b10100;
	localparam logic [4:0] opArsh = 5'b10110;

	// ----------------------------------------
	// status flags
	// ----------------------------------------

	// bit positions in the flag word
	localparam int flagC = 0;
	localparam int flagL = 1;
	localparam int flagF = 2;
	localparam int flagZ = 3;
	localparam int flagN = 4;

	typedef logic [4:0] flags_t;

	// update masks per opcode class
	localparam flags_t maskArith = flags_t'((1 << flagC) | (1 << flagF));
	localparam flags_t maskCarry = flags_t'(1 << flagC);
	localparam flags_t maskCmp = flags_t'((1 << flagL) | (1 << flagZ) | (1 << flagN));

	// ----------------------------------------
	// instruction word
	// ----------------------------------------

	// register form
	typedef struct packed
	{
		logic [4:0] opCode;
		logic [3:0] rDest;
		logic [3:0] rSrc;
		logic [3:0] pad;
	} regForm_s;

	// immediate form
	// low byte holds the 8-bit immediate
	typedef struct packed
	{
		logic [4:0] opCode;
		logic [3:0] rDest;
		logic [7:0] imm;
	} immForm_s;

	// same 17 bits seen both ways
	typedef union packed
	{
		regForm_s regForm;
		immForm_s immForm;
	} instr_u;

	// alu output bundle
	typedef struct packed
	{
		logic [15:0] result;
		flags_t flags;
		flags_t flagMask;
		logic writeEn;
		logic [10:0] pad;
	} aluResult_s;

endpackage

`default_nettype wire

// ==== source/regFile.sv ====
`default_nettype none

module regFile
(
	input wire clk,
	input wire arstN,
	input wire writeEn,
	input wire [3:0] writeAddr,
	input wire [15:0] writeData,
	input wire [3:0] readAddrA,
	input wire [3:0] readAddrB,
	input wire [3:0] dbgAddr,
	output logic [15:0] readDataA,
	output logic [15:0] readDataB,
	output logic [15:0] dbgData
);

	// ----------------------------------------
	// register array
	// ----------------------------------------

	// sixteen general registers
	logic [15:0] regs [16];

	// single write port, one cycle
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			// whole file cleared on reset
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end
		else if (writeEn)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// ----------------------------------------
	// read ports
	// ----------------------------------------

	// asynchronous, zero cycle
	// rDest side
	assign readDataA = regs[readAddrA];
	// rSrc side
	assign readDataB = regs[readAddrB];
	// debug observation port
	assign dbgData = regs[dbgAddr];

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// alu result must be fully known whenever it is stored
	writeKnown: assert property (
		@(posedge clk) disable iff (!arstN)
		writeEn |-> !$isunknown(writeData)
	) else $error("unknown write data at address %0d", writeAddr);

endmodule

`default_nettype wire

// ==== source/operandSelect.sv ====
`default_nettype none

module operandSelect
(
	input wire aluPkg::instr_u instr,
	input wire [15:0] regB,
	output logic [15:0] opB
);

	// immediate view of the word
	logic [4:0] opCode;
	logic [7:0] imm;
	logic signExt;
	logic zeroExt;

	assign opCode = instr.immForm.opCode;
	assign imm = instr.immForm.imm;

	// ----------------------------------------
	// immediate decode
	// ----------------------------------------

	always_comb
	begin
		signExt = 1'b0;
		zeroExt = 1'b0;
		case (opCode)
			// signed immediates
			aluPkg::opAddi, aluPkg::opAddci, aluPkg::opSubi, aluPkg::opCmpi:
				signExt = 1'b1;
			// unsigned immediates
			// shift immediates also land here, alu uses bits 3..0
			aluPkg::opAddui, aluPkg::opAddcui, aluPkg::opCmpui,
			aluPkg::opLshi, aluPkg::opRshi:
				zeroExt = 1'b1;
			default:
			begin
				signExt = 1'b0;
				zeroExt = 1'b0;
			end
		endcase
	end

	// ----------------------------------------
	// operand mux
	// ----------------------------------------

	always_comb
	begin
		if (signExt)
			opB = {{8{imm[7]}}, imm};
		else if (zeroExt)
			opB = {8'h00, imm};
		else
			// register form passes the source register
			opB = regB;
	end

endmodule

`default_nettype wire

// ==== alu/alu.sv ====
`default_nettype none

module alu
(
	input wire [4:0] opCode,
	input wire [15:0] opA,
	input wire [15:0] opB,
	input wire carryIn,
	output aluPkg::aluResult_s res
);

	// ----------------------------------------
	// arithmetic datapath
	// ----------------------------------------

	// 17-bit so bit 16 is carry or borrow
	logic [16:0] sum;
	logic [16:0] diff;
	logic cin;
	logic useCarry;
	logic isSub;
	logic addOvf;
	logic subOvf;

	// shifter results
	logic [3:0] shAmt;
	logic [15:0] shl;
	logic [15:0] shr;
	logic [15:0] sar;

	// selected outputs
	logic [15:0] aluOut;
	aluPkg::flags_t newFlags;
	aluPkg::flags_t mask;
	logic wr;

	// stored C only feeds the carry adds
	assign useCarry = (opCode == aluPkg::opAddc) || (opCode == aluPkg::opAddci)
		|| (opCode == aluPkg::opAddcu) || (opCode == aluPkg::opAddcui);
	assign isSub = (opCode == aluPkg::opSub) || (opCode == aluPkg::opSubi);
	assign cin = useCarry & carryIn;

	assign sum = {1'b0, opA} + {1'b0, opB} + {16'b0, cin};
	// bit 16 set means borrow, i.e. unsigned opA < opB
	assign diff = {1'b0, opA} - {1'b0, opB};

	// signed overflow
	// same-sign inputs with a flipped sign out
	assign addOvf = (opA[15] == opB[15]) && (sum[15] != opA[15]);
	// differing signs and result sign differs from opA
	assign subOvf = (opA[15] != opB[15]) && (diff[15] != opA[15]);

	// ----------------------------------------
	// shifts
	// ----------------------------------------

	// only low nibble counts for every shift
	assign shAmt = opB[3:0];
	assign shl = opA << shAmt;
	assign shr = opA >> shAmt;
	assign sar = $signed(opA) >>> shAmt;

	// ----------------------------------------
	// flag formation
	// ----------------------------------------

	// all five always formed, mask picks which land
	always_comb
	begin
		newFlags[aluPkg::flagC] = isSub ? diff[16] : sum[16];
		newFlags[aluPkg::flagL] = diff[16];
		newFlags[aluPkg::flagF] = isSub ? subOvf : addOvf;
		newFlags[aluPkg::flagZ] = (opA == opB);
		newFlags[aluPkg::flagN] = $signed(opA) < $signed(opB);
	end

	// ----------------------------------------
	// opcode class decode and result select
	// ----------------------------------------

	always_comb
	begin
		// undefined codes fall through as no-ops
		aluOut = '0;
		mask = '0;
		wr = 1'b0;
		case (opCode)
			aluPkg::opAdd, aluPkg::opAddi, aluPkg::opAddc, aluPkg::opAddci:
			begin
				aluOut = sum[15:0];
				mask = aluPkg::maskArith;
				wr = 1'b1;
			end
			// unsigned adds touch only C
			aluPkg::opAddu, aluPkg::opAddui, aluPkg::opAddcu, aluPkg::opAddcui:
			begin
				aluOut = sum[15:0];
				mask = aluPkg::maskCarry;
				wr = 1'b1;
			end
			aluPkg::opSub, aluPkg::opSubi:
			begin
				aluOut = diff[15:0];
				mask = aluPkg::maskArith;
				wr = 1'b1;
			end
			// compares update flags only
			aluPkg::opCmp, aluPkg::opCmpi, aluPkg::opCmpui:
			begin
				aluOut = diff[15:0];
				mask = aluPkg::maskCmp;
			end
			// logic and shifts leave flags alone
			aluPkg::opAnd:
			begin
				aluOut = opA & opB;
				wr = 1'b1;
			end
			aluPkg::opOr:
			begin
				aluOut = opA | opB;
				wr = 1'b1;
			end
			aluPkg::opXor:
			begin
				aluOut = opA ^ opB;
				wr = 1'b1;
			end
			aluPkg::opNot:
			begin
				// inverse of the source operand
				aluOut = ~opB;
				wr = 1'b1;
			end
			aluPkg::opLsh, aluPkg::opLshi:
			begin
				aluOut = shl;
				wr = 1'b1;
			end
			aluPkg::opRsh, aluPkg::opRshi:
			begin
				aluOut = shr;
				wr = 1'b1;
			end
			aluPkg::opArsh:
			begin
				aluOut = sar;
				wr = 1'b1;
			end
			default:
			begin
				wr = 1'b0;
			end
		endcase
		// raw compare codes checked against the write enable
		if (opCode inside {aluPkg::opCmp, aluPkg::opCmpi, aluPkg::opCmpui})
			cmpNoWrite: assert (!wr)
				else $error("compare opcode raised writeEn");
	end

	assign res = '{result: aluOut, flags: newFlags, flagMask: mask, writeEn: wr, pad: '0};

endmodule

`default_nettype wire

// ==== alu/statusReg.sv ====
`default_nettype none

module statusReg
(
	input wire clk,
	input wire arstN,
	input wire update,
	input wire aluPkg::flags_t newFlags,
	input wire aluPkg::flags_t flagMask,
	output aluPkg::flags_t flags,
	output logic carryIn
);

	// ----------------------------------------
	// flag storage
	// ----------------------------------------

	// next value merges new bits under the mask
	aluPkg::flags_t merged;

	// masked bits from alu and the rest kept
	assign merged = (flags & ~flagMask) | (newFlags & flagMask);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			// all flags clear out of reset
			flags <= '0;
		end
		else if (update)
		begin
			flags <= merged;
		end
	end

	// ----------------------------------------
	// carry feedback
	// ----------------------------------------

	// stored C back to the alu for addc family
	assign carryIn = flags[aluPkg::flagC];

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// idle cycles hold every flag
	flagsHold: assert property (
		@(posedge clk) disable iff (!arstN)
		!update |=> $stable(flags)
	) else $error("flags changed without an update");

endmodule

`default_nettype wire

// ==== source/execCore.sv ====
`default_nettype none

module execCore
(
	input wire clk,
	input wire arstN,
	input wire instrValid,
	input wire aluPkg::instr_u instr,
	input wire [3:0] dbgAddr,
	output logic [15:0] dbgData,
	output aluPkg::flags_t flags
);

	// ----------------------------------------
	// datapath nets
	// ----------------------------------------

	// rDest value, first operand and write target
	logic [15:0] opA;
	// rSrc value before the immediate mux
	logic [15:0] regB;
	// second alu operand
	logic [15:0] opB;
	// stored C looped back
	logic carryIn;
	// alu bundle
	aluPkg::aluResult_s aluRes;
	// gated write strobe
	logic regWrite;

	// writes only land with a valid instruction
	assign regWrite = instrValid & aluRes.writeEn;

	// ----------------------------------------
	// register file
	// ----------------------------------------

	regFile regs
	(
		.clk(clk),
		.arstN(arstN),
		.writeEn(regWrite),
		.writeAddr(instr.regForm.rDest),
		.writeData(aluRes.result),
		.readAddrA(instr.regForm.rDest),
		.readAddrB(instr.regForm.rSrc),
		.dbgAddr(dbgAddr),
		.readDataA(opA),
		.readDataB(regB),
		.dbgData(dbgData)
	);

	// register or extended immediate
	operandSelect opSel
	(
		.instr(instr),
		.regB(regB),
		.opB(opB)
	);

	// ----------------------------------------
	// execute and status
	// ----------------------------------------

	alu aluUnit
	(
		.opCode(instr.regForm.opCode),
		.opA(opA),
		.opB(opB),
		.carryIn(carryIn),
		.res(aluRes)
	);

	// flags load on the same edge as the register write
	statusReg status
	(
		.clk(clk),
		.arstN(arstN),
		.update(instrValid),
		.newFlags(aluRes.flags),
		.flagMask(aluRes.flagMask),
		.flags(flags),
		.carryIn(carryIn)
	);

endmodule

`default_nettype wire

// ==== verif/execCoreTb.sv ====
`default_nettype none

module execCoreTb;

	// ----------------------------------------
	// run length and watchdog
	// ----------------------------------------

	localparam int nArith = 400;
	localparam int nCmp = 200;
	localparam int nLogic = 300;
	localparam int nBad = 50;
	// 3 reset cycles plus four sweeps of 16 plus 48 loading plus the random runs
	// about 1065 cycles of work and close to 3x headroom
	localparam int cycleLimit = 3000;

	logic clk;
	logic arstN;
	logic instrValid;
	aluPkg::instr_u instr;
	logic [3:0] dbgAddr;
	logic [15:0] dbgData;
	aluPkg::flags_t flags;

	// reference state
	logic [15:0] mRegs [16];
	aluPkg::flags_t mFlags;
	logic [15:0] lfsrState;

	// opcode pools per test
	logic [4:0] arithOps [10];
	logic [4:0] cmpOps [3];
	logic [4:0] logicOps [9];
	logic [4:0] badOps [10];

	int cycleCount;
	int testNum;
	int testErrors;
	int errorCount;
	int failedTests;

	execCore uut
	(
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData),
		.flags(flags)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	// hung run ends here
	initial
	begin
		while (cycleCount < cycleLimit)
			@(posedge clk);
		$display("timeout: run did not finish within %0d cycles", cycleLimit);
		$display("tests failed");
		$finish;
	end

	// ----------------------------------------
	// random source
	// ----------------------------------------

	// taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one step per bit and the newest bit lands at the bottom
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			val = {val[14:0], lfsrState[0]};
		end
		return val;
	endfunction

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	task automatic modelExec(input logic [4:0] op, input logic [3:0] rd, input logic [7:0] low8);
		logic [15:0] a;
		logic [15:0] src;
		logic [15:0] b;
		logic [15:0] r;
		logic wr;
		logic arith;
		logic cOnly;
		logic isSub;
		logic isCmp;
		int ci;
		int ua;
		int ub;
		int sa;
		int sb;
		int us;
		int ss;
		a = mRegs[rd];
		// register form keeps rSrc in the top nibble of the low byte
		src = mRegs[low8[7:4]];
		r = '0;
		ci = 0;
		// second operand by immediate kind
		if (op inside {aluPkg::opAddi, aluPkg::opAddci, aluPkg::opSubi, aluPkg::opCmpi})
			b = {{8{low8[7]}}, low8};
		else if (op inside {aluPkg::opAddui, aluPkg::opAddcui, aluPkg::opCmpui})
			b = {8'h00, low8};
		else
			b = src;
		// carry adds pick up the stored C
		if (op inside {aluPkg::opAddc, aluPkg::opAddci, aluPkg::opAddcu, aluPkg::opAddcui})
			ci = int'(mFlags[aluPkg::flagC]);
		// opcode classes
		arith = op inside {aluPkg::opAdd, aluPkg::opAddi, aluPkg::opAddc, aluPkg::opAddci};
		cOnly = op inside {aluPkg::opAddu, aluPkg::opAddui, aluPkg::opAddcu, aluPkg::opAddcui};
		isSub = op inside {aluPkg::opSub, aluPkg::opSubi};
		isCmp = op inside {aluPkg::opCmp, aluPkg::opCmpi, aluPkg::opCmpui};
		// logic and shifts
		wr = 1'b1;
		case (op)
			aluPkg::opAnd:
				r = a & src;
			aluPkg::opOr:
				r = a | src;
			aluPkg::opXor:
				r = a ^ src;
			aluPkg::opNot:
				r = ~src;
			aluPkg::opLsh:
				r = a << src[3:0];
			aluPkg::opLshi:
				r = a << low8[3:0];
			aluPkg::opRsh:
				r = a >> src[3:0];
			aluPkg::opRshi:
				r = a >> low8[3:0];
			aluPkg::opArsh:
				r = $signed(a) >>> src[3:0];
			default:
				wr = 1'b0;
		endcase
		// wide integer view so carry and overflow fall out of the range
		ua = int'(a);
		ub = int'(b);
		sa = int'($signed(a));
		sb = int'($signed(b));
		if (arith || cOnly)
		begin
			us = ua + ub + ci;
			ss = sa + sb + ci;
			r = us[15:0];
			wr = 1'b1;
			mFlags[aluPkg::flagC] = (us > 65535);
			if (arith)
				mFlags[aluPkg::flagF] = (ss > 32767) || (ss < -32768);
		end
		if (isSub)
		begin
			us = ua - ub;
			ss = sa - sb;
			r = us[15:0];
			wr = 1'b1;
			// borrow
			mFlags[aluPkg::flagC] = (ua < ub);
			mFlags[aluPkg::flagF] = (ss > 32767) || (ss < -32768);
		end
		if (isCmp)
		begin
			mFlags[aluPkg::flagL] = (ua < ub);
			mFlags[aluPkg::flagZ] = (ua == ub);
			mFlags[aluPkg::flagN] = (sa < sb);
		end
		if (wr)
			mRegs[rd] = r;
	endtask

	// ----------------------------------------
	// drive and compare
	// ----------------------------------------

	task automatic compareWord(input logic [3:0] addr, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: r%0d read %h, expected %h", $time, addr, got, exp);
			testErrors++;
		end
	endtask

	task automatic compareFlags(input aluPkg::flags_t got, input aluPkg::flags_t exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: flags NZFLC read %b, expected %b", $time, got, exp);
			testErrors++;
		end
	endtask

	// called on a falling edge and returns on the next one
	// back to back calls keep one instruction per cycle
	task automatic runInstr(input logic [4:0] op, input logic [3:0] rd, input logic [7:0] low8);
		instr = aluPkg::instr_u'({op, rd, low8});
		instrValid = 1'b1;
		// watch the destination as the result lands
		dbgAddr = rd;
		modelExec(op, rd, low8);
		@(negedge clk);
		compareWord(rd, dbgData, mRegs[rd]);
		compareFlags(flags, mFlags);
		instrValid = 1'b0;
	endtask

	// whole register file at one register per cycle
	task automatic sweepRegs();
		for (int i = 0; i < 16; i++)
		begin
			dbgAddr = 4'(i);
			@(negedge clk);
			compareWord(4'(i), dbgData, mRegs[i]);
		end
		compareFlags(flags, mFlags);
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0)
			$display("test %0d %s: ok", testNum, name);
		else
			$display("test %0d %s: %0d mismatches", testNum, name, testErrors);
		errorCount += testErrors;
		if (testErrors != 0)
			failedTests++;
		testErrors = 0;
		testNum++;
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------

	initial
	begin
		logic [4:0] op;
		logic [3:0] rd;
		logic [7:0] low8;
		logic [15:0] val;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		dbgAddr = '0;
		cycleCount = 0;
		testNum = 1;
		testErrors = 0;
		errorCount = 0;
		failedTests = 0;
		lfsrState = 16'd56;
		mFlags = '0;
		for (int i = 0; i < 16; i++)
			mRegs[i] = '0;
		arithOps = '{aluPkg::opAdd, aluPkg::opAddi, aluPkg::opAddu, aluPkg::opAddui,
			aluPkg::opAddc, aluPkg::opAddci, aluPkg::opAddcu, aluPkg::opAddcui,
			aluPkg::opSub, aluPkg::opSubi};
		cmpOps = '{aluPkg::opCmp, aluPkg::opCmpi, aluPkg::opCmpui};
		logicOps = '{aluPkg::opAnd, aluPkg::opOr, aluPkg::opXor, aluPkg::opNot,
			aluPkg::opLsh, aluPkg::opLshi, aluPkg::opRsh, aluPkg::opRshi, aluPkg::opArsh};
		badOps = '{5'b10101, 5'b10111, 5'b11000, 5'b11001, 5'b11010,
			5'b11011, 5'b11100, 5'b11101, 5'b11110, 5'b11111};
		repeat (3) @(negedge clk);
		arstN = 1'b1;

		// everything zero out of reset
		sweepRegs();
		finishTest("reset state");

		// high byte then shift up then low byte
		for (int r = 0; r < 16; r++)
		begin
			val = takeBits(16);
			runInstr(aluPkg::opAddui, 4'(r), val[15:8]);
			runInstr(aluPkg::opLshi, 4'(r), 8'd8);
			runInstr(aluPkg::opAddui, 4'(r), val[7:0]);
		end
		sweepRegs();
		finishTest("register loading");

		for (int i = 0; i < nArith; i++)
		begin
			op = arithOps[int'(takeBits(4)) % 10];
			// every fourth one chains on the stored carry
			if (i % 4 == 3)
				op = takeBits(1) != 0 ? aluPkg::opAddc : aluPkg::opAddci;
			rd = 4'(takeBits(4));
			low8 = 8'(takeBits(8));
			runInstr(op, rd, low8);
		end
		finishTest("arithmetic");

		for (int i = 0; i < nCmp; i++)
		begin
			op = cmpOps[int'(takeBits(2)) % 3];
			rd = 4'(takeBits(4));
			low8 = 8'(takeBits(8));
			// register against itself so Z must rise
			if (i % 10 == 9)
			begin
				op = aluPkg::opCmp;
				low8 = {rd, low8[3:0]};
			end
			runInstr(op, rd, low8);
		end
		sweepRegs();
		finishTest("compare");

		for (int i = 0; i < nLogic; i++)
		begin
			op = logicOps[int'(takeBits(4)) % 9];
			rd = 4'(takeBits(4));
			low8 = 8'(takeBits(8));
			runInstr(op, rd, low8);
		end
		finishTest("logic and shift");

		for (int i = 0; i < nBad; i++)
		begin
			op = badOps[int'(takeBits(4)) % 10];
			rd = 4'(takeBits(4));
			low8 = 8'(takeBits(8));
			runInstr(op, rd, low8);
		end
		sweepRegs();
		finishTest("undefined opcodes");

		$display("summary: %0d tests run, %0d with mismatches, %0d mismatches overall",
			testNum - 1, failedTests, errorCount);
		if (failedTests == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== execCore.f ====
common/aluPkg.sv
source/regFile.sv
source/operandSelect.sv
alu/alu.sv
alu/statusReg.sv
source/execCore.sv
verif/execCoreTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
	-f execCore.f \
	--top-module execCoreTb \
	-o execCoreSim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/execCoreSim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
